// ==== vlog.f ====
pcs_tx_pkg.sv
pcs_csr_axil.sv
block_encoder.sv
block_scrambler.sv
am_scheduler.sv
lane_distributor.sv
pcs_tx_top.sv
tb_clock_gen.sv
pcs_tx_asserts.sv
pcs_tx_tb.sv

// ==== pcs_tx_tb.sv ====
// testbench for the transmit PCS: registers, encoding, scrambling and marker insertion
module pcs_tx_tb;
    import pcs_tx_pkg::*;

    localparam int         CLK_PERIOD     = 40;
    localparam int         RESET_CYCLES   = 16;
    localparam int         PLANNED_WORDS  = 100;
    localparam int         TIMEOUT_CYCLES = PLANNED_WORDS * 8 + 2000;
    localparam logic [1:0] RESP_OKAY      = 2'b00;
    localparam logic [1:0] RESP_SLVERR    = 2'b10;

    logic        clock;
    logic        rst_n;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    xgmii_word_t tx_word;
    logic        tx_valid;
    logic        tx_ready;
    lane_group_t lanes;
    logic        lane_valid;

    integer       seed;
    int           errors;
    logic         bypass_model;
    logic [57:0]  scr_model;
    coded_block_t exp_q [$];
    lane_group_t  out_q [$];

    tb_clock_gen u_clock_gen (.o_clock(clock));

    pcs_tx_top pcs_tx_top_i
    (
        .i_clock      (clock),
        .i_rst_n      (rst_n),
        .i_awaddr     (awaddr),
        .i_awvalid    (awvalid),
        .o_awready    (awready),
        .i_wdata      (wdata),
        .i_wstrb      (wstrb),
        .i_wvalid     (wvalid),
        .o_wready     (wready),
        .o_bresp      (bresp),
        .o_bvalid     (bvalid),
        .i_bready     (bready),
        .i_araddr     (araddr),
        .i_arvalid    (arvalid),
        .o_arready    (arready),
        .o_rdata      (rdata),
        .o_rresp      (rresp),
        .o_rvalid     (rvalid),
        .i_rready     (rready),
        .i_tx_word    (tx_word),
        .i_tx_valid   (tx_valid),
        .o_tx_ready   (tx_ready),
        .o_lanes      (lanes),
        .o_lane_valid (lane_valid)
    );

    // lane groups are stable at the falling edge
    always @(negedge clock)
    begin
        if (rst_n && lane_valid)
            out_q.push_back(lanes);
    end

    task automatic expect_equal(input string name, input logic [65:0] expected,
                                input logic [65:0] actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
            errors++;
        end
    endtask

    // 64b/66b rules for data, idle, start and error blocks
    function automatic coded_block_t encode_ref(input xgmii_word_t word);
        coded_block_t blk;
        blk.sh = 2'b10;
        if (word.ctrl == 8'h00)
        begin
            blk.sh      = 2'b01;
            blk.payload = word.data;
        end
        else if (word.ctrl == 8'hFF && word.data == {8{8'h07}})
            blk.payload = {56'd0, 8'h1E};
        else if (word.ctrl == 8'h01 && word.data[7:0] == 8'hFB)
            blk.payload = {word.data[63:8], 8'h78};
        else
            blk.payload = {{8{7'h1E}}, 8'h1E};
        return blk;
    endfunction

    // 1 + x^39 + x^58, lsb first, state kept in the bench
    function automatic logic [63:0] scramble_ref(input logic [63:0] payload);
        logic [63:0] result;
        logic        bit_out;
        for (int i = 0; i < 64; i++)
        begin
            bit_out   = payload[i] ^ scr_model[38] ^ scr_model[57];
            result[i] = bit_out;
            scr_model = {scr_model[56:0], bit_out};
        end
        return result;
    endfunction

    function automatic xgmii_word_t rand_word(input logic [7:0] ctrl);
        xgmii_word_t word;
        word.data = {$random(seed), $random(seed)};
        word.ctrl = ctrl;
        return word;
    endfunction

    task automatic reset_dut();
        rst_n     = 1'b0;
        scr_model = '0;
        repeat (RESET_CYCLES) @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        // ready follows valid, address and data go in at the next rising edge
        wait (awready && wready);
        @(negedge clock);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid)
            @(negedge clock);
        resp = bresp;
        @(negedge clock);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        while (!arready)
            @(negedge clock);
        @(negedge clock);
        arvalid = 1'b0;
        while (!rvalid)
            @(negedge clock);
        data = rdata;
        resp = rresp;
        @(negedge clock);
        rready = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        expect_equal("bresp", RESP_OKAY, resp);
    endtask

    task automatic read_check(input string name, input logic [3:0] addr,
                              input logic [31:0] expected);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, data, resp);
        expect_equal(name, expected, data);
        expect_equal("rresp", RESP_OKAY, resp);
    endtask

    task automatic send_word(input xgmii_word_t word);
        tx_word  = word;
        tx_valid = 1'b1;
        while (!tx_ready)
            @(negedge clock);
        @(negedge clock);
        tx_valid = 1'b0;
    endtask

    task automatic stream_word(input xgmii_word_t word);
        coded_block_t blk;
        blk = encode_ref(word);
        if (!bypass_model)
            blk.payload = scramble_ref(blk.payload);
        exp_q.push_back(blk);
        send_word(word);
    endtask

    task automatic check_output(input int n_groups);
        lane_group_t grp;
        coded_block_t blk;
        while (out_q.size() < n_groups)
            @(negedge clock);
        // room for any group that should not be there
        repeat (8) @(negedge clock);
        expect_equal("lane group count", n_groups, out_q.size());
        for (int g = 0; g < n_groups; g++)
        begin
            grp = out_q.pop_front();
            for (int l = 0; l < N_LANES; l++)
            begin
                blk = exp_q.pop_front();
                expect_equal($sformatf("o_lanes[%0d] group %0d", l, g), blk, grp[l]);
            end
        end
        out_q.delete();
        exp_q.delete();
    endtask

    task automatic register_access();
        logic [31:0] data;
        logic [1:0]  resp;
        read_check("CTRL", 4'h0, 32'h0);
        read_check("AM_PERIOD", 4'h4, 32'd16);
        read_check("AM_COUNT", 4'h8, 32'h0);
        write_reg(4'h0, 32'h3);
        read_check("CTRL", 4'h0, 32'h3);
        write_reg(4'h4, 32'h1234);
        read_check("AM_PERIOD", 4'h4, 32'h1234);
        write_reg(4'h4, 32'h1);
        read_check("AM_PERIOD", 4'h4, 32'h2);
        axi_write(4'hC, 32'hFFFF_FFFF, resp);
        expect_equal("bresp", RESP_SLVERR, resp);
        axi_read(4'hC, data, resp);
        expect_equal("rresp", RESP_SLVERR, resp);
        expect_equal("rdata", 32'h0, data);
        write_reg(4'h0, 32'h0);
        write_reg(4'h4, 32'd16);
    endtask

    task automatic disabled_path();
        int groups_before;
        groups_before = out_q.size();
        tx_word  = rand_word(8'h00);
        tx_valid = 1'b1;
        repeat (50)
        begin
            @(negedge clock);
            expect_equal("o_tx_ready", 1'b0, tx_ready);
        end
        tx_valid = 1'b0;
        expect_equal("lane group count", groups_before, out_q.size());
    endtask

    task automatic bypassed_data();
        write_reg(4'h0, 32'h3);
        bypass_model = 1'b1;
        repeat (16) stream_word(rand_word(8'h00));
        check_output(4);
    endtask

    task automatic control_encoding();
        xgmii_word_t word;
        word      = rand_word(8'hFF);
        word.data = {8{8'h07}};
        stream_word(word);
        word           = rand_word(8'h01);
        word.data[7:0] = 8'hFB;
        stream_word(word);
        // start character missing from byte 0
        word           = rand_word(8'h01);
        word.data[7:0] = 8'h55;
        stream_word(word);
        word      = rand_word(8'hFF);
        word.data = {{7{8'h07}}, 8'hFD};
        stream_word(word);
        check_output(1);
    endtask

    task automatic scrambled_data();
        write_reg(4'h0, 32'h1);
        bypass_model = 1'b0;
        repeat (32) stream_word(rand_word(8'h00));
        check_output(8);
    endtask

    task automatic marker_insertion();
        coded_block_t marker;
        reset_dut();
        write_reg(4'h4, 32'd3);
        write_reg(4'h0, 32'h3);
        bypass_model = 1'b1;
        for (int g = 0; g < 12; g++)
        begin
            repeat (4) stream_word(rand_word(8'h00));
            if (g % 3 == 2)
            begin
                for (int l = 0; l < N_LANES; l++)
                begin
                    marker.sh      = 2'b10;
                    marker.payload = AM_LANE_CODE[l];
                    exp_q.push_back(marker);
                end
            end
        end
        check_output(16);
        read_check("AM_COUNT", 4'h8, 32'd4);
    endtask

    initial
    begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d", errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        seed         = 63;
        errors       = 0;
        bypass_model = 1'b0;
        scr_model    = '0;
        rst_n        = 1'b0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        tx_word      = '0;
        tx_valid     = 1'b0;
        reset_dut();
        register_access();
        disabled_path();
        bypassed_data();
        control_encoding();
        scrambled_data();
        marker_insertion();
        errors += pcs_tx_top_i.u_asserts.fail_count;
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== pcs_tx_asserts.sv ====
// concurrent checks on distributor stall, lane output spacing and scrambler valid
module pcs_tx_asserts
(
    input logic                     i_clock,
    input logic                     i_rst_n,
    input pcs_tx_pkg::dist_state_e  i_state,
    input pcs_tx_pkg::coded_block_t i_scr_block,
    input logic                     i_lane_valid,
    input logic                     i_word_accepted,
    input logic                     i_scr_valid
);
    import pcs_tx_pkg::*;

    int   fail_count = 0;
    logic seen_word;

    // set by the first word taken at the stream input
    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
            seen_word <= 1'b0;
        else if (i_word_accepted)
            seen_word <= 1'b1;
    end

    // no advance in the marker cycle, so the scrambler output holds
    hold_in_marker: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        i_state == ST_MARKER |=> $stable(i_scr_block) && $stable(i_scr_valid)
    )
    else
    begin
        fail_count++;
        $error("scrambler output moved while the distributor sent markers");
    end

    // back to back groups only when the second one is the marker group
    lane_valid_spacing: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        i_lane_valid && $past(i_lane_valid) |-> i_state == ST_MARKER
    )
    else
    begin
        fail_count++;
        $error("two lane groups in a row without a marker group");
    end

    quiet_until_first_word: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        !seen_word |-> !i_scr_valid
    )
    else
    begin
        fail_count++;
        $error("scrambler output valid before any word was accepted");
    end

endmodule

bind pcs_tx_top pcs_tx_asserts u_asserts
(
    .i_clock         (i_clock),
    .i_rst_n         (i_rst_n),
    .i_state         (u_distributor.state),
    .i_scr_block     (u_scrambler.o_block),
    .i_lane_valid    (u_distributor.o_lane_valid),
    .i_word_accepted (i_tx_valid && o_tx_ready),
    .i_scr_valid     (u_scrambler.o_valid)
);

// ==== tb_clock_gen.sv ====
// testbench clock source with a 40-unit period
module tb_clock_gen
(
    output logic o_clock
);
    localparam int HALF_PERIOD = 20;

    initial
    begin
        o_clock = 1'b0;
        forever
        begin
            #(HALF_PERIOD);
            o_clock = ~o_clock;
        end
    end

endmodule

// ==== pcs_tx_top.sv ====
// transmit PCS top: register block, encoder, scrambler, marker scheduler, lanes
module pcs_tx_top
(
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  logic [3:0]              i_awaddr,
    input  logic                    i_awvalid,
    output logic                    o_awready,
    input  logic [31:0]             i_wdata,
    input  logic [3:0]              i_wstrb,
    input  logic                    i_wvalid,
    output logic                    o_wready,
    output logic [1:0]              o_bresp,
    output logic                    o_bvalid,
    input  logic                    i_bready,
    input  logic [3:0]              i_araddr,
    input  logic                    i_arvalid,
    output logic                    o_arready,
    output logic [31:0]             o_rdata,
    output logic [1:0]              o_rresp,
    output logic                    o_rvalid,
    input  logic                    i_rready,
    input  pcs_tx_pkg::xgmii_word_t i_tx_word,
    input  logic                    i_tx_valid,
    output logic                    o_tx_ready,
    output pcs_tx_pkg::lane_group_t o_lanes,
    output logic                    o_lane_valid
);
    import pcs_tx_pkg::*;

    csr_cfg_t     cfg;
    coded_block_t enc_block;
    coded_block_t scr_block;
    lane_group_t  markers;
    logic         enc_valid;
    logic         scr_valid;
    logic         advance;
    logic         group_done;
    logic         marker_due;
    logic         marker_taken;
    logic         marker_sent;

    // advance already folds in enable and the marker stall
    assign o_tx_ready = advance;

    pcs_csr_axil u_csr
    (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_awaddr      (i_awaddr),
        .i_awvalid     (i_awvalid),
        .o_awready     (o_awready),
        .i_wdata       (i_wdata),
        .i_wstrb       (i_wstrb),
        .i_wvalid      (i_wvalid),
        .o_wready      (o_wready),
        .o_bresp       (o_bresp),
        .o_bvalid      (o_bvalid),
        .i_bready      (i_bready),
        .i_araddr      (i_araddr),
        .i_arvalid     (i_arvalid),
        .o_arready     (o_arready),
        .o_rdata       (o_rdata),
        .o_rresp       (o_rresp),
        .o_rvalid      (o_rvalid),
        .i_rready      (i_rready),
        .i_marker_sent (marker_sent),
        .o_cfg         (cfg)
    );

    block_encoder u_encoder
    (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_advance (advance),
        .i_word    (i_tx_word),
        .i_valid   (i_tx_valid),
        .o_block   (enc_block),
        .o_valid   (enc_valid)
    );

    block_scrambler u_scrambler
    (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_advance (advance),
        .i_bypass  (cfg.bypass),
        .i_block   (enc_block),
        .i_valid   (enc_valid),
        .o_block   (scr_block),
        .o_valid   (scr_valid)
    );

    am_scheduler u_am_scheduler
    (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_period       (cfg.am_period),
        .i_group_done   (group_done),
        .i_marker_taken (marker_taken),
        .o_marker_due   (marker_due),
        .o_markers      (markers),
        .o_marker_sent  (marker_sent)
    );

    lane_distributor u_distributor
    (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_enable       (cfg.enable),
        .i_block        (scr_block),
        .i_valid        (scr_valid),
        .i_marker_due   (marker_due),
        .i_markers      (markers),
        .o_advance      (advance),
        .o_group_done   (group_done),
        .o_marker_taken (marker_taken),
        .o_lanes        (o_lanes),
        .o_lane_valid   (o_lane_valid)
    );

endmodule

// ==== lane_distributor.sv ====
// deals coded blocks onto four lanes and swaps in marker groups on demand
module lane_distributor
(
    input  logic                     i_clock,
    input  logic                     i_rst_n,
    input  logic                     i_enable,
    input  pcs_tx_pkg::coded_block_t i_block,
    input  logic                     i_valid,
    input  logic                     i_marker_due,
    input  pcs_tx_pkg::lane_group_t  i_markers,
    output logic                     o_advance,
    output logic                     o_group_done,
    output logic                     o_marker_taken,
    output pcs_tx_pkg::lane_group_t  o_lanes,
    output logic                     o_lane_valid
);
    import pcs_tx_pkg::*;

    dist_state_e  state;
    logic [1:0]   slot_idx;
    coded_block_t slot_q [N_LANES-1];
    lane_group_t  group_next;
    logic         slot_last;

    assign slot_last      = (slot_idx == 2'(N_LANES - 1));
    assign o_advance      = i_enable && (state == ST_FILL);
    assign o_group_done   = o_advance && i_valid && slot_last;
    assign o_marker_taken = (state == ST_MARKER);

    // held slots plus the block completing the group
    always_comb
    begin
        for (int l = 0; l < N_LANES - 1; l++)
        begin
            group_next[l] = slot_q[l];
        end
        group_next[N_LANES-1] = i_block;
    end

    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state        <= ST_FILL;
            slot_idx     <= '0;
            o_lane_valid <= 1'b0;
        end
        else
        begin
            o_lane_valid <= 1'b0;
            case (state)
                ST_FILL:
                begin
                    if (o_advance && i_valid)
                        slot_idx <= slot_last ? 2'd0 : slot_idx + 2'd1;
                    if (o_group_done)
                        o_lane_valid <= 1'b1;
                    // marker goes out the cycle after the group that made it due
                    else if (o_advance && i_marker_due)
                    begin
                        state        <= ST_MARKER;
                        o_lane_valid <= 1'b1;
                    end
                end
                default: state <= ST_FILL;
            endcase
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (o_advance && i_valid && !slot_last)
            slot_q[slot_idx] <= i_block;
        if (o_group_done)
            o_lanes <= group_next;
        else if (state == ST_FILL && o_advance && i_marker_due)
            o_lanes <= i_markers;
    end

endmodule

// ==== am_scheduler.sv ====
// counts data groups and flags when a marker group is due
module am_scheduler
(
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  logic [15:0]             i_period,
    input  logic                    i_group_done,
    input  logic                    i_marker_taken,
    output logic                    o_marker_due,
    output pcs_tx_pkg::lane_group_t o_markers,
    output logic                    o_marker_sent
);
    import pcs_tx_pkg::*;

    logic [15:0] group_count;
    logic [15:0] count_inc;

    assign count_inc     = group_count + 16'd1;
    assign o_marker_sent = i_marker_taken;

    // a lowered period takes effect at the next group
    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            group_count  <= '0;
            o_marker_due <= 1'b0;
        end
        else if (i_marker_taken)
        begin
            group_count  <= '0;
            o_marker_due <= 1'b0;
        end
        else if (i_group_done)
        begin
            group_count <= count_inc;
            if (count_inc >= i_period)
                o_marker_due <= 1'b1;
        end
    end

    always_comb
    begin
        for (int l = 0; l < N_LANES; l++)
        begin
            o_markers[l].sh      = SH_CTRL;
            o_markers[l].payload = AM_LANE_CODE[l];
        end
    end

endmodule

// ==== block_scrambler.sv ====
// self-synchronous payload scrambler, 1 + x^39 + x^58, with bypass
module block_scrambler
(
    input  logic                     i_clock,
    input  logic                     i_rst_n,
    input  logic                     i_advance,
    input  logic                     i_bypass,
    input  pcs_tx_pkg::coded_block_t i_block,
    input  logic                     i_valid,
    output pcs_tx_pkg::coded_block_t o_block,
    output logic                     o_valid
);
    import pcs_tx_pkg::*;

    logic [NB_SCR_STATE-1:0] scr_state;
    logic [NB_SCR_STATE-1:0] state_walk;
    logic [NB_SCR_STATE-1:0] state_next;
    logic [NB_PAYLOAD-1:0]   payload_scr;
    logic                    scr_bit;
    logic                    load;

    assign load = i_advance && i_valid;

    // lsb first, each scrambled bit feeds back into the state
    always_comb
    begin
        state_walk = scr_state;
        for (int i = 0; i < NB_PAYLOAD; i++)
        begin
            scr_bit        = i_block.payload[i] ^ state_walk[SCR_TAP_A] ^ state_walk[SCR_TAP_B];
            payload_scr[i] = scr_bit;
            state_walk     = {state_walk[NB_SCR_STATE-2:0], scr_bit};
        end
        state_next = state_walk;
    end

    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_valid   <= 1'b0;
            scr_state <= '0;
        end
        else
        begin
            if (i_advance)
                o_valid <= i_valid;
            // state frozen while bypassed
            if (load && !i_bypass)
                scr_state <= state_next;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (load)
        begin
            o_block.sh      <= i_block.sh;
            o_block.payload <= i_bypass ? i_block.payload : payload_scr;
        end
    end

endmodule

// ==== block_encoder.sv ====
// 64b/66b block encoder for data, idle, start and error blocks, holds on stall
module block_encoder
(
    input  logic                     i_clock,
    input  logic                     i_rst_n,
    input  logic                     i_advance,
    input  pcs_tx_pkg::xgmii_word_t  i_word,
    input  logic                     i_valid,
    output pcs_tx_pkg::coded_block_t o_block,
    output logic                     o_valid
);
    import pcs_tx_pkg::*;

    block_type_e  blk_type;
    coded_block_t blk_next;

    // classify the incoming word
    always_comb
    begin
        if (i_word.ctrl == '0)
            blk_type = BLK_DATA;
        else if (i_word.ctrl == '1 && i_word.data == {NB_CTRL{XGMII_IDLE}})
            blk_type = BLK_IDLE;
        else if (i_word.ctrl == 8'h01 && i_word.data[7:0] == XGMII_START)
            blk_type = BLK_START;
        else
            blk_type = BLK_ERROR;
    end

    // type byte sits in the low byte of the payload
    always_comb
    begin
        case (blk_type)
            BLK_DATA:
            begin
                blk_next.sh      = SH_DATA;
                blk_next.payload = i_word.data;
            end
            BLK_IDLE:
            begin
                blk_next.sh      = SH_CTRL;
                blk_next.payload = {56'd0, BT_IDLE};
            end
            BLK_START:
            begin
                // start replaces byte 0, lanes 1 to 7 carry data
                blk_next.sh      = SH_CTRL;
                blk_next.payload = {i_word.data[63:8], BT_START};
            end
            default:
            begin
                blk_next.sh      = SH_CTRL;
                blk_next.payload = {{NB_CTRL{CC_ERROR}}, BT_IDLE};
            end
        endcase
    end

    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_valid <= 1'b0;
        else if (i_advance)
            o_valid <= i_valid;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_advance && i_valid)
            o_block <= blk_next;
    end

endmodule

// ==== pcs_csr_axil.sv ====
// AXI4-Lite register block holding enable, bypass, marker period and marker count
module pcs_csr_axil
(
    input  logic                 i_clock,
    input  logic                 i_rst_n,
    input  logic [3:0]           i_awaddr,
    input  logic                 i_awvalid,
    output logic                 o_awready,
    input  logic [31:0]          i_wdata,
    input  logic [3:0]           i_wstrb,
    input  logic                 i_wvalid,
    output logic                 o_wready,
    output logic [1:0]           o_bresp,
    output logic                 o_bvalid,
    input  logic                 i_bready,
    input  logic [3:0]           i_araddr,
    input  logic                 i_arvalid,
    output logic                 o_arready,
    output logic [31:0]          o_rdata,
    output logic [1:0]           o_rresp,
    output logic                 o_rvalid,
    input  logic                 i_rready,
    input  logic                 i_marker_sent,
    output pcs_tx_pkg::csr_cfg_t o_cfg
);
    import pcs_tx_pkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    csr_cfg_t    cfg_q;
    logic [15:0] am_count_q;
    logic [15:0] period_wr;
    logic        wr_go;
    logic        rd_go;

    // address and data are taken together, one write in flight
    assign wr_go     = i_awvalid && i_wvalid && !o_bvalid;
    assign rd_go     = i_arvalid && !o_rvalid;
    assign o_awready = wr_go;
    assign o_wready  = wr_go;
    assign o_arready = !o_rvalid;
    assign o_cfg     = cfg_q;

    // byte-masked period, clamped so data still flows between markers
    always_comb
    begin
        period_wr[7:0]  = i_wstrb[0] ? i_wdata[7:0]  : cfg_q.am_period[7:0];
        period_wr[15:8] = i_wstrb[1] ? i_wdata[15:8] : cfg_q.am_period[15:8];
        if (period_wr < AM_PERIOD_MIN)
        begin
            period_wr = AM_PERIOD_MIN;
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            cfg_q.enable    <= 1'b0;
            cfg_q.bypass    <= 1'b0;
            cfg_q.am_period <= AM_PERIOD_RESET;
            o_bvalid        <= 1'b0;
            o_bresp         <= RESP_OKAY;
        end
        else
        begin
            if (wr_go)
            begin
                o_bvalid <= 1'b1;
                o_bresp  <= RESP_OKAY;
                case (i_awaddr)
                    CSR_CTRL:
                    begin
                        if (i_wstrb[0])
                        begin
                            cfg_q.enable <= i_wdata[0];
                            cfg_q.bypass <= i_wdata[1];
                        end
                    end
                    CSR_AM_PERIOD: cfg_q.am_period <= period_wr;
                    // read-only counter and holes both refuse writes
                    default: o_bresp <= RESP_SLVERR;
                endcase
            end
            else if (o_bvalid && i_bready)
            begin
                o_bvalid <= 1'b0;
            end
        end
    end

    // marker groups sent, wraps at 16 bits
    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
            am_count_q <= '0;
        else if (i_marker_sent)
            am_count_q <= am_count_q + 16'd1;
    end

    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_rvalid <= 1'b0;
        else if (rd_go)
            o_rvalid <= 1'b1;
        else if (i_rready)
            o_rvalid <= 1'b0;
    end

    always_ff @(posedge i_clock)
    begin
        if (rd_go)
        begin
            o_rresp <= RESP_OKAY;
            case (i_araddr)
                CSR_CTRL:      o_rdata <= {30'd0, cfg_q.bypass, cfg_q.enable};
                CSR_AM_PERIOD: o_rdata <= {16'd0, cfg_q.am_period};
                CSR_AM_COUNT:  o_rdata <= {16'd0, am_count_q};
                default:
                begin
                    o_rdata <= '0;
                    o_rresp <= RESP_SLVERR;
                end
            endcase
        end
    end

endmodule

// ==== pcs_tx_pkg.sv ====
// shared types, constants and marker table for the four-lane transmit PCS
package pcs_tx_pkg;

    localparam int N_LANES         = 4;
    localparam int NB_PAYLOAD      = 64;
    localparam int NB_CTRL         = 8;
    localparam int NB_SH           = 2;
    localparam int NB_SCR_STATE    = 58;
    localparam int SCR_TAP_A       = 38;
    localparam int SCR_TAP_B       = 57;
    localparam logic [15:0] AM_PERIOD_RESET = 16'd16;
    localparam logic [15:0] AM_PERIOD_MIN   = 16'd2;

    localparam logic [NB_SH-1:0] SH_DATA = 2'b01;
    localparam logic [NB_SH-1:0] SH_CTRL = 2'b10;

    // block type bytes and control characters
    localparam logic [7:0] BT_IDLE     = 8'h1E;
    localparam logic [7:0] BT_START    = 8'h78;
    localparam logic [6:0] CC_ERROR    = 7'h1E;
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hFB;

    typedef struct packed {
        logic [NB_PAYLOAD-1:0] data;
        logic [NB_CTRL-1:0]    ctrl;
    } xgmii_word_t;

    typedef struct packed {
        logic [NB_SH-1:0]      sh;
        logic [NB_PAYLOAD-1:0] payload;
    } coded_block_t;

    // lane 0 carries the first block of a group
    typedef coded_block_t [N_LANES-1:0] lane_group_t;

    typedef struct packed {
        logic        enable;
        logic        bypass;
        logic [15:0] am_period;
    } csr_cfg_t;

    typedef enum logic [1:0] {BLK_DATA, BLK_IDLE, BLK_START, BLK_ERROR} block_type_e;

    typedef enum logic [3:0] {
        CSR_CTRL      = 4'h0,
        CSR_AM_PERIOD = 4'h4,
        CSR_AM_COUNT  = 4'h8
    } csr_addr_e;

    typedef enum logic {ST_FILL, ST_MARKER} dist_state_e;

    // per-lane marker payloads, M0 in the low byte, BIP fields fixed
    localparam logic [NB_PAYLOAD-1:0] AM_LANE_CODE [N_LANES] = '{
        64'hFF_DE_97_3E_00_21_68_C1,
        64'hFF_71_8E_62_00_8E_71_9D,
        64'hFF_17_B4_A6_00_E8_4B_59,
        64'hFF_84_6A_B2_00_7B_95_4D
    };

endpackage
